//--- sc_pkg.sv
package sc_pkg;

    // Pixel channel and coordinate widths
    localparam int COLOR_W = 8;
    localparam int COORD_W = 12;

    // Repeat factors (minus one), scanline strength and mask brightness
    localparam int RPT_W = 4;

    // Line buffer geometry
    localparam int LB_LINES  = 4;
    localparam int LB_LINE_W = 64;
    localparam int LB_X_W    = 6;
    localparam int LB_Y_W    = 2;

    // Pipeline stage numbers, counted from the H/V counter state
    //   1  sync, DE, coordinates and buffer address registered
    //   2  buffer read data valid, timing delayed to match
    //   3  mask flag and scanline subtraction
    //   4  test pattern / mask / colour select, top-level outputs
    localparam int PP_TIMING  = 1;
    localparam int PP_LINEBUF = PP_TIMING + 1;
    localparam int PP_SLGEN   = PP_LINEBUF + 1;
    localparam int PP_TP      = PP_SLGEN + 1;

    // Cycles from counter state to the top-level outputs
    localparam int PP_LATENCY = PP_TP;

    // One colour channel value
    typedef logic [COLOR_W-1:0] color_t;

    // Counter or pixel coordinate
    typedef logic [COORD_W-1:0] coord_t;

    // Repeat factor minus one, or a 4-bit strength / brightness
    typedef logic [RPT_W-1:0] rpt_t;

    // Pixel index within a buffered line
    typedef logic [LB_X_W-1:0] lb_x_t;

    // Line slot within the buffer
    typedef logic [LB_Y_W-1:0] lb_y_t;

endpackage

//--- sc_timing_gen.sv
module sc_timing_gen (
    input  logic           PCLK_OUT_i,
    input  logic           reset_i,
    input  sc_pkg::coord_t h_total_i,
    input  sc_pkg::coord_t h_active_i,
    input  sc_pkg::coord_t h_synclen_i,
    input  sc_pkg::coord_t h_backporch_i,
    input  sc_pkg::coord_t v_total_i,
    input  sc_pkg::coord_t v_active_i,
    input  sc_pkg::coord_t v_synclen_i,
    input  sc_pkg::coord_t v_backporch_i,
    input  sc_pkg::rpt_t   x_rpt_i,
    input  sc_pkg::rpt_t   y_rpt_i,
    input  logic           sl_enable_i,
    output logic           hsync_o,
    output logic           vsync_o,
    output logic           de_o,
    output sc_pkg::coord_t xpos_o,
    output sc_pkg::coord_t ypos_o,
    output sc_pkg::lb_x_t  rd_x_o,
    output sc_pkg::lb_y_t  rd_y_o,
    output logic           sl_row_o
);

    sc_pkg::coord_t h_cnt;
    sc_pkg::coord_t v_cnt;

    // Active window bounds in counter space
    sc_pkg::coord_t h_start;
    sc_pkg::coord_t h_end;
    sc_pkg::coord_t v_start;
    sc_pkg::coord_t v_end;

    logic h_act;
    logic v_act;
    logic h_last;
    logic v_last;
    logic h_act_last;
    logic v_act_last;

    // Repeat sub-counters and source indices for the current counter state
    sc_pkg::rpt_t  x_sub;
    sc_pkg::lb_x_t src_x;
    sc_pkg::rpt_t  y_sub;
    sc_pkg::lb_y_t src_y;

    assign h_start = h_synclen_i + h_backporch_i;
    assign h_end   = h_start + h_active_i;
    assign v_start = v_synclen_i + v_backporch_i;
    assign v_end   = v_start + v_active_i;

    assign h_act = (h_cnt >= h_start) && (h_cnt < h_end);
    assign v_act = (v_cnt >= v_start) && (v_cnt < v_end);

    assign h_last = (h_cnt == h_total_i - 1'b1);
    assign v_last = (v_cnt == v_total_i - 1'b1);

    // Last active pixel of a line and last active line of a frame
    assign h_act_last = (h_cnt == h_end - 1'b1);
    assign v_act_last = (v_cnt == v_end - 1'b1);

    always_ff @(posedge PCLK_OUT_i) begin
        if (reset_i) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
            if (v_last) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // Horizontal repeat, source pixel steps every x_rpt+1 output pixels
    always_ff @(posedge PCLK_OUT_i) begin
        if (reset_i) begin
            x_sub <= '0;
            src_x <= '0;
        end else if (h_act && !h_act_last) begin
            if (x_sub == x_rpt_i) begin
                x_sub <= '0;
                src_x <= src_x + 1'b1;
            end else begin
                x_sub <= x_sub + 1'b1;
            end
        end else begin
            x_sub <= '0;
            src_x <= '0;
        end
    end

    // Vertical repeat, advanced once per line at the end of the line
    always_ff @(posedge PCLK_OUT_i) begin
        if (reset_i) begin
            y_sub <= '0;
            src_y <= '0;
        end else if (h_last) begin
            if (v_act && !v_act_last) begin
                if (y_sub == y_rpt_i) begin
                    y_sub <= '0;
                    src_y <= src_y + 1'b1;
                end else begin
                    y_sub <= y_sub + 1'b1;
                end
            end else begin
                y_sub <= '0;
                src_y <= '0;
            end
        end
    end

    // Stage 1 registers
    always_ff @(posedge PCLK_OUT_i) begin
        if (reset_i) begin
            hsync_o  <= 1'b1;
            vsync_o  <= 1'b1;
            de_o     <= 1'b0;
            xpos_o   <= '0;
            ypos_o   <= '0;
            rd_x_o   <= '0;
            rd_y_o   <= '0;
            sl_row_o <= 1'b0;
        end else begin
            hsync_o  <= (h_cnt >= h_synclen_i);
            vsync_o  <= (v_cnt >= v_synclen_i);
            de_o     <= h_act && v_act;
            xpos_o   <= (h_act && v_act) ? h_cnt - h_start : '0;
            ypos_o   <= (h_act && v_act) ? v_cnt - v_start : '0;
            rd_x_o   <= src_x;
            rd_y_o   <= src_y;
            // Darken the last output line of each repeat group
            sl_row_o <= sl_enable_i && (y_rpt_i != '0) && (y_sub == y_rpt_i);
        end
    end

    // Active coordinates stay inside the configured line width
    a_de_xpos_in_range: assert property (
        @(posedge PCLK_OUT_i) disable iff (reset_i)
        de_o |-> (xpos_o < h_active_i)
    ) else $error("xpos_o out of active range while de_o is high");

endmodule

//--- sc_line_buffer.sv
module sc_line_buffer (
    input  logic           PCLK_OUT_i,
    input  logic           we_i,
    input  sc_pkg::lb_x_t  wr_x_i,
    input  sc_pkg::lb_y_t  wr_y_i,
    input  sc_pkg::color_t wr_r_i,
    input  sc_pkg::color_t wr_g_i,
    input  sc_pkg::color_t wr_b_i,
    input  sc_pkg::lb_x_t  rd_x_i,
    input  sc_pkg::lb_y_t  rd_y_i,
    output sc_pkg::color_t rd_r_o,
    output sc_pkg::color_t rd_g_o,
    output sc_pkg::color_t rd_b_o
);

    localparam int WORD_W = 3 * sc_pkg::COLOR_W;

    // One RGB triple per entry, packed as {r, g, b}
    logic [WORD_W-1:0] mem [sc_pkg::LB_LINES][sc_pkg::LB_LINE_W];

    logic [WORD_W-1:0] wr_word;
    logic [WORD_W-1:0] rd_word;

    assign wr_word = {wr_r_i, wr_g_i, wr_b_i};

    // Write port
    always_ff @(posedge PCLK_OUT_i) begin
        if (we_i) begin
            mem[wr_y_i][wr_x_i] <= wr_word;
        end
    end

    // Registered read, a same-cycle write returns the old entry
    always_ff @(posedge PCLK_OUT_i) begin
        rd_word <= mem[rd_y_i][rd_x_i];
    end

    assign rd_r_o = rd_word[3*sc_pkg::COLOR_W-1:2*sc_pkg::COLOR_W];
    assign rd_g_o = rd_word[2*sc_pkg::COLOR_W-1:sc_pkg::COLOR_W];
    assign rd_b_o = rd_word[sc_pkg::COLOR_W-1:0];

    // Capture writes carry a fully defined address
    a_wr_addr_known: assert property (
        @(posedge PCLK_OUT_i)
        we_i |-> !$isunknown({wr_y_i, wr_x_i})
    ) else $error("line buffer write with unknown address");

endmodule

//--- sc_postproc.sv
module sc_postproc (
    input  logic           PCLK_OUT_i,
    input  logic           reset_i,
    input  logic           hsync_i,
    input  logic           vsync_i,
    input  logic           de_i,
    input  sc_pkg::coord_t xpos_i,
    input  sc_pkg::coord_t ypos_i,
    input  logic           sl_row_i,
    input  sc_pkg::color_t r_i,
    input  sc_pkg::color_t g_i,
    input  sc_pkg::color_t b_i,
    input  sc_pkg::rpt_t   sl_str_i,
    input  sc_pkg::coord_t mask_x_start_i,
    input  sc_pkg::coord_t mask_x_size_i,
    input  sc_pkg::coord_t mask_y_start_i,
    input  sc_pkg::coord_t mask_y_size_i,
    input  sc_pkg::rpt_t   mask_br_i,
    input  logic           testpattern_i,
    output sc_pkg::color_t r_o,
    output sc_pkg::color_t g_o,
    output sc_pkg::color_t b_o,
    output logic           hsync_o,
    output logic           vsync_o,
    output logic           de_o,
    output sc_pkg::coord_t xpos_o,
    output sc_pkg::coord_t ypos_o
);

    // Timing and coordinate delay line, stage 2 up to the output stage
    logic           hsync_pp [sc_pkg::PP_LINEBUF:sc_pkg::PP_LATENCY];
    logic           vsync_pp [sc_pkg::PP_LINEBUF:sc_pkg::PP_LATENCY];
    logic           de_pp    [sc_pkg::PP_LINEBUF:sc_pkg::PP_LATENCY];
    sc_pkg::coord_t xpos_pp  [sc_pkg::PP_LINEBUF:sc_pkg::PP_LATENCY];
    sc_pkg::coord_t ypos_pp  [sc_pkg::PP_LINEBUF:sc_pkg::PP_LATENCY];

    // Scanline flag at stage 2, mask flag at stage 3
    logic sl_row_q;
    logic mask_q;

    // Stage 3 colour after scanline subtraction
    sc_pkg::color_t r_sl;
    sc_pkg::color_t g_sl;
    sc_pkg::color_t b_sl;

    // Window end points carry one extra bit so start + size cannot wrap
    logic [sc_pkg::COORD_W:0] mask_x_end;
    logic [sc_pkg::COORD_W:0] mask_y_end;
    logic                     in_window;

    sc_pkg::color_t sl_thold;
    sc_pkg::color_t mask_val;
    sc_pkg::color_t tp_val;

    function automatic sc_pkg::color_t sat_sub(input sc_pkg::color_t pix,
                                               input sc_pkg::color_t thold);
        return (pix > thold) ? pix - thold : '0;
    endfunction

    assign mask_x_end = {1'b0, mask_x_start_i} + {1'b0, mask_x_size_i};
    assign mask_y_end = {1'b0, mask_y_start_i} + {1'b0, mask_y_size_i};

    assign in_window = (xpos_pp[sc_pkg::PP_LINEBUF] >= mask_x_start_i) &&
                       ({1'b0, xpos_pp[sc_pkg::PP_LINEBUF]} < mask_x_end) &&
                       (ypos_pp[sc_pkg::PP_LINEBUF] >= mask_y_start_i) &&
                       ({1'b0, ypos_pp[sc_pkg::PP_LINEBUF]} < mask_y_end);

    // (sl_str+1)*16-1 is the strength in the high nibble over all ones
    assign sl_thold = {sl_str_i, 4'hf};

    assign mask_val = {mask_br_i, mask_br_i};

    assign tp_val = sc_pkg::color_t'(xpos_pp[sc_pkg::PP_SLGEN] ^ ypos_pp[sc_pkg::PP_SLGEN]);

    always_ff @(posedge PCLK_OUT_i) begin
        if (reset_i) begin
            for (int i = sc_pkg::PP_LINEBUF; i <= sc_pkg::PP_LATENCY; i++) begin
                hsync_pp[i] <= 1'b1;
                vsync_pp[i] <= 1'b1;
                de_pp[i]    <= 1'b0;
                xpos_pp[i]  <= '0;
                ypos_pp[i]  <= '0;
            end
            sl_row_q <= 1'b0;
        end else begin
            hsync_pp[sc_pkg::PP_LINEBUF] <= hsync_i;
            vsync_pp[sc_pkg::PP_LINEBUF] <= vsync_i;
            de_pp[sc_pkg::PP_LINEBUF]    <= de_i;
            xpos_pp[sc_pkg::PP_LINEBUF]  <= xpos_i;
            ypos_pp[sc_pkg::PP_LINEBUF]  <= ypos_i;
            for (int i = sc_pkg::PP_LINEBUF + 1; i <= sc_pkg::PP_LATENCY; i++) begin
                hsync_pp[i] <= hsync_pp[i-1];
                vsync_pp[i] <= vsync_pp[i-1];
                de_pp[i]    <= de_pp[i-1];
                xpos_pp[i]  <= xpos_pp[i-1];
                ypos_pp[i]  <= ypos_pp[i-1];
            end
            sl_row_q <= sl_row_i;
        end
    end

    // Stage 3, mask flag
    always_ff @(posedge PCLK_OUT_i) begin
        if (reset_i) begin
            mask_q <= 1'b0;
        end else begin
            mask_q <= !in_window;
        end
    end

    // Stage 3, subtractive scanline on flagged rows
    always_ff @(posedge PCLK_OUT_i) begin
        r_sl <= sl_row_q ? sat_sub(r_i, sl_thold) : r_i;
        g_sl <= sl_row_q ? sat_sub(g_i, sl_thold) : g_i;
        b_sl <= sl_row_q ? sat_sub(b_i, sl_thold) : b_i;
    end

    // Stage 4, test pattern overrides mask, mask overrides picture
    always_ff @(posedge PCLK_OUT_i) begin
        if (reset_i) begin
            r_o <= '0;
            g_o <= '0;
            b_o <= '0;
        end else if (testpattern_i) begin
            r_o <= tp_val;
            g_o <= tp_val;
            b_o <= tp_val;
        end else if (mask_q) begin
            r_o <= mask_val;
            g_o <= mask_val;
            b_o <= mask_val;
        end else begin
            r_o <= r_sl;
            g_o <= g_sl;
            b_o <= b_sl;
        end
    end

    assign hsync_o = hsync_pp[sc_pkg::PP_LATENCY];
    assign vsync_o = vsync_pp[sc_pkg::PP_LATENCY];
    assign de_o    = de_pp[sc_pkg::PP_LATENCY];
    assign xpos_o  = xpos_pp[sc_pkg::PP_LATENCY];
    assign ypos_o  = ypos_pp[sc_pkg::PP_LATENCY];

    // Active video never overlaps horizontal sync at the output
    a_de_outside_hsync: assert property (
        @(posedge PCLK_OUT_i) disable iff (reset_i)
        de_o |-> hsync_o
    ) else $error("de_o high during hsync_o pulse");

endmodule

//--- scanconverter.sv
module scanconverter (
    input  logic           PCLK_OUT_i,
    input  logic           reset_i,
    input  sc_pkg::coord_t h_total_i,
    input  sc_pkg::coord_t h_active_i,
    input  sc_pkg::coord_t h_synclen_i,
    input  sc_pkg::coord_t h_backporch_i,
    input  sc_pkg::coord_t v_total_i,
    input  sc_pkg::coord_t v_active_i,
    input  sc_pkg::coord_t v_synclen_i,
    input  sc_pkg::coord_t v_backporch_i,
    input  sc_pkg::rpt_t   x_rpt_i,
    input  sc_pkg::rpt_t   y_rpt_i,
    input  logic           sl_enable_i,
    input  sc_pkg::rpt_t   sl_str_i,
    input  sc_pkg::coord_t mask_x_start_i,
    input  sc_pkg::coord_t mask_x_size_i,
    input  sc_pkg::coord_t mask_y_start_i,
    input  sc_pkg::coord_t mask_y_size_i,
    input  sc_pkg::rpt_t   mask_br_i,
    input  logic           testpattern_i,
    input  logic           cap_we_i,
    input  sc_pkg::lb_x_t  cap_x_i,
    input  sc_pkg::lb_y_t  cap_y_i,
    input  sc_pkg::color_t cap_r_i,
    input  sc_pkg::color_t cap_g_i,
    input  sc_pkg::color_t cap_b_i,
    output sc_pkg::color_t r_o,
    output sc_pkg::color_t g_o,
    output sc_pkg::color_t b_o,
    output logic           hsync_o,
    output logic           vsync_o,
    output logic           de_o,
    output sc_pkg::coord_t xpos_o,
    output sc_pkg::coord_t ypos_o
);

    // Stage 1 timing from the generator
    logic           tg_hsync;
    logic           tg_vsync;
    logic           tg_de;
    sc_pkg::coord_t tg_xpos;
    sc_pkg::coord_t tg_ypos;
    logic           tg_sl_row;

    // Buffer read address (stage 1) and data (stage 2)
    sc_pkg::lb_x_t  rd_x;
    sc_pkg::lb_y_t  rd_y;
    sc_pkg::color_t rd_r;
    sc_pkg::color_t rd_g;
    sc_pkg::color_t rd_b;

    sc_timing_gen sc_timing_gen_i (
        .PCLK_OUT_i    (PCLK_OUT_i),
        .reset_i       (reset_i),
        .h_total_i     (h_total_i),
        .h_active_i    (h_active_i),
        .h_synclen_i   (h_synclen_i),
        .h_backporch_i (h_backporch_i),
        .v_total_i     (v_total_i),
        .v_active_i    (v_active_i),
        .v_synclen_i   (v_synclen_i),
        .v_backporch_i (v_backporch_i),
        .x_rpt_i       (x_rpt_i),
        .y_rpt_i       (y_rpt_i),
        .sl_enable_i   (sl_enable_i),
        .hsync_o       (tg_hsync),
        .vsync_o       (tg_vsync),
        .de_o          (tg_de),
        .xpos_o        (tg_xpos),
        .ypos_o        (tg_ypos),
        .rd_x_o        (rd_x),
        .rd_y_o        (rd_y),
        .sl_row_o      (tg_sl_row)
    );

    sc_line_buffer sc_line_buffer_i (
        .PCLK_OUT_i (PCLK_OUT_i),
        .we_i       (cap_we_i),
        .wr_x_i     (cap_x_i),
        .wr_y_i     (cap_y_i),
        .wr_r_i     (cap_r_i),
        .wr_g_i     (cap_g_i),
        .wr_b_i     (cap_b_i),
        .rd_x_i     (rd_x),
        .rd_y_i     (rd_y),
        .rd_r_o     (rd_r),
        .rd_g_o     (rd_g),
        .rd_b_o     (rd_b)
    );

    sc_postproc sc_postproc_i (
        .PCLK_OUT_i     (PCLK_OUT_i),
        .reset_i        (reset_i),
        .hsync_i        (tg_hsync),
        .vsync_i        (tg_vsync),
        .de_i           (tg_de),
        .xpos_i         (tg_xpos),
        .ypos_i         (tg_ypos),
        .sl_row_i       (tg_sl_row),
        .r_i            (rd_r),
        .g_i            (rd_g),
        .b_i            (rd_b),
        .sl_str_i       (sl_str_i),
        .mask_x_start_i (mask_x_start_i),
        .mask_x_size_i  (mask_x_size_i),
        .mask_y_start_i (mask_y_start_i),
        .mask_y_size_i  (mask_y_size_i),
        .mask_br_i      (mask_br_i),
        .testpattern_i  (testpattern_i),
        .r_o            (r_o),
        .g_o            (g_o),
        .b_o            (b_o),
        .hsync_o        (hsync_o),
        .vsync_o        (vsync_o),
        .de_o           (de_o),
        .xpos_o         (xpos_o),
        .ypos_o         (ypos_o)
    );

endmodule

//--- tb_scanconverter.sv
module tb_scanconverter;

    // Small output mode
    localparam int H_TOTAL     = 40;
    localparam int H_ACTIVE    = 16;
    localparam int H_SYNCLEN   = 4;
    localparam int H_BACKPORCH = 6;
    localparam int V_TOTAL     = 12;
    localparam int V_ACTIVE    = 4;
    localparam int V_SYNCLEN   = 2;
    localparam int V_BACKPORCH = 3;

    localparam int FRAME_CYCLES   = H_TOTAL * V_TOTAL;
    localparam int FILL_CYCLES    = sc_pkg::LB_LINES * sc_pkg::LB_LINE_W;
    localparam int RESET_CYCLES   = 5;
    localparam int WATCH_CYCLES   = 2 * FRAME_CYCLES + 4 * sc_pkg::PP_LATENCY;
    localparam int NUM_TESTS      = 5;
    localparam int TIMEOUT_CYCLES =
        NUM_TESTS * (RESET_CYCLES + FILL_CYCLES + WATCH_CYCLES + 4) + 100;

    logic           pclk_out;
    logic           reset;
    sc_pkg::rpt_t   x_rpt;
    sc_pkg::rpt_t   y_rpt;
    logic           sl_enable;
    sc_pkg::rpt_t   sl_str;
    sc_pkg::coord_t mask_x_start;
    sc_pkg::coord_t mask_x_size;
    sc_pkg::coord_t mask_y_start;
    sc_pkg::coord_t mask_y_size;
    sc_pkg::rpt_t   mask_br;
    logic           testpattern;
    logic           cap_we;
    sc_pkg::lb_x_t  cap_x;
    sc_pkg::lb_y_t  cap_y;
    sc_pkg::color_t cap_r;
    sc_pkg::color_t cap_g;
    sc_pkg::color_t cap_b;

    sc_pkg::color_t r;
    sc_pkg::color_t g;
    sc_pkg::color_t b;
    logic           hsync;
    logic           vsync;
    logic           de;
    sc_pkg::coord_t xpos;
    sc_pkg::coord_t ypos;

    // Reference copy of the line buffer with {r, g, b} per entry
    logic [3*sc_pkg::COLOR_W-1:0] ref_mem [sc_pkg::LB_LINES][sc_pkg::LB_LINE_W];
    logic [31:0] rng_state;
    int          cycle_count = 0;

    scanconverter scanconverter_i (
        .PCLK_OUT_i     (pclk_out),
        .reset_i        (reset),
        .h_total_i      (sc_pkg::coord_t'(H_TOTAL)),
        .h_active_i     (sc_pkg::coord_t'(H_ACTIVE)),
        .h_synclen_i    (sc_pkg::coord_t'(H_SYNCLEN)),
        .h_backporch_i  (sc_pkg::coord_t'(H_BACKPORCH)),
        .v_total_i      (sc_pkg::coord_t'(V_TOTAL)),
        .v_active_i     (sc_pkg::coord_t'(V_ACTIVE)),
        .v_synclen_i    (sc_pkg::coord_t'(V_SYNCLEN)),
        .v_backporch_i  (sc_pkg::coord_t'(V_BACKPORCH)),
        .x_rpt_i        (x_rpt),
        .y_rpt_i        (y_rpt),
        .sl_enable_i    (sl_enable),
        .sl_str_i       (sl_str),
        .mask_x_start_i (mask_x_start),
        .mask_x_size_i  (mask_x_size),
        .mask_y_start_i (mask_y_start),
        .mask_y_size_i  (mask_y_size),
        .mask_br_i      (mask_br),
        .testpattern_i  (testpattern),
        .cap_we_i       (cap_we),
        .cap_x_i        (cap_x),
        .cap_y_i        (cap_y),
        .cap_r_i        (cap_r),
        .cap_g_i        (cap_g),
        .cap_b_i        (cap_b),
        .r_o            (r),
        .g_o            (g),
        .b_o            (b),
        .hsync_o        (hsync),
        .vsync_o        (vsync),
        .de_o           (de),
        .xpos_o         (xpos),
        .ypos_o         (ypos)
    );

    always #4 pclk_out = ~pclk_out;

    always @(posedge pclk_out) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected 0x%0h actual 0x%0h", name, expected, actual);
            abort_run();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Expected channel value at an active pixel (ch 0 is red and 2 is blue)
    function automatic logic [7:0] expected_channel(input int x, input int y, input int ch);
        logic [23:0] word;
        int          p;
        int          thr;
        if (testpattern) begin
            return 8'((x ^ y) & 'hff);
        end
        if (x < int'(mask_x_start) || x >= int'(mask_x_start) + int'(mask_x_size) ||
            y < int'(mask_y_start) || y >= int'(mask_y_start) + int'(mask_y_size)) begin
            return {mask_br, mask_br};
        end
        word = ref_mem[(y / (int'(y_rpt) + 1)) % sc_pkg::LB_LINES][x / (int'(x_rpt) + 1)];
        p = int'(word[23-8*ch -: 8]);
        if (sl_enable && y_rpt != '0 && (y % (int'(y_rpt) + 1)) == int'(y_rpt)) begin
            thr = (int'(sl_str) + 1) * 16 - 1;
            p = (p > thr) ? p - thr : 0;
        end
        return 8'(p);
    endfunction

    task automatic set_defaults();
        x_rpt        = '0;
        y_rpt        = '0;
        sl_enable    = 1'b0;
        sl_str       = '0;
        mask_x_start = '0;
        mask_x_size  = sc_pkg::coord_t'(H_ACTIVE);
        mask_y_start = '0;
        mask_y_size  = sc_pkg::coord_t'(V_ACTIVE);
        mask_br      = '0;
        testpattern  = 1'b0;
        cap_we       = 1'b0;
        cap_x        = '0;
        cap_y        = '0;
        cap_r        = '0;
        cap_g        = '0;
        cap_b        = '0;
    endtask

    // Enter reset on a falling edge so the configuration loads while reset is high
    task automatic begin_test();
        @(negedge pclk_out);
        reset = 1'b1;
        set_defaults();
    endtask

    // Observe two frames of output and check timing, coordinates and pixels
    task automatic watch_frames();
        int   since_rise;
        int   de_run;
        int   hs_run;
        int   vs_run;
        int   lines;
        int   frames;
        int   pixels;
        int   exp_x;
        logic de_prev;
        logic hs_prev;
        logic vs_prev;
        logic in_frame;
        since_rise = 0;
        de_run     = 0;
        hs_run     = 0;
        vs_run     = 0;
        lines      = 0;
        frames     = 0;
        pixels     = 0;
        exp_x      = 0;
        de_prev    = 1'b0;
        hs_prev    = 1'b1;
        vs_prev    = 1'b1;
        in_frame   = 1'b0;
        for (int c = 0; c < WATCH_CYCLES; c++) begin
            @(negedge pclk_out);
            if (de) begin
                if (!de_prev) begin
                    if (lines > 0) begin
                        check_value("de_o line period", H_TOTAL, since_rise);
                    end
                    since_rise = 0;
                    de_run     = 0;
                    exp_x      = 0;
                    lines++;
                end
                check_value("xpos_o", exp_x, 32'(xpos));
                check_value("ypos_o", lines - 1, 32'(ypos));
                check_value("r_o", 32'(expected_channel(exp_x, lines - 1, 0)), 32'(r));
                check_value("g_o", 32'(expected_channel(exp_x, lines - 1, 1)), 32'(g));
                check_value("b_o", 32'(expected_channel(exp_x, lines - 1, 2)), 32'(b));
                exp_x++;
                de_run++;
                pixels++;
            end else if (de_prev) begin
                check_value("de_o run length", H_ACTIVE, de_run);
            end
            since_rise++;
            if (!hsync) begin
                hs_run++;
            end else if (!hs_prev) begin
                check_value("hsync_o low length", H_SYNCLEN, hs_run);
                hs_run = 0;
            end
            if (!vsync) begin
                // Falling vsync marks a frame boundary
                if (vs_prev) begin
                    if (in_frame) begin
                        check_value("de_o lines per frame", V_ACTIVE, lines);
                        frames++;
                    end
                    in_frame = 1'b1;
                    lines    = 0;
                end
                vs_run++;
            end else if (!vs_prev) begin
                check_value("vsync_o low length", V_SYNCLEN * H_TOTAL, vs_run);
                vs_run = 0;
            end
            de_prev = de;
            hs_prev = hsync;
            vs_prev = vsync;
        end
        if (frames != 2 || pixels != 2 * H_ACTIVE * V_ACTIVE) begin
            $display("Expected two complete frames, saw %0d frames and %0d pixels",
                     frames, pixels);
            abort_run();
        end
    endtask

    // Hold reset, check the idle outputs, load the buffer, then release and watch
    task automatic fill_and_watch();
        repeat (RESET_CYCLES) @(negedge pclk_out);
        check_value("hsync_o", 1, 32'(hsync));
        check_value("vsync_o", 1, 32'(vsync));
        check_value("de_o", 0, 32'(de));
        check_value("r_o", 0, 32'(r));
        check_value("g_o", 0, 32'(g));
        check_value("b_o", 0, 32'(b));
        check_value("xpos_o", 0, 32'(xpos));
        check_value("ypos_o", 0, 32'(ypos));
        for (int y = 0; y < sc_pkg::LB_LINES; y++) begin
            for (int x = 0; x < sc_pkg::LB_LINE_W; x++) begin
                rng_state  = xorshift32(rng_state);
                ref_mem[y][x] = rng_state[23:0];
                cap_we     = 1'b1;
                cap_x      = x[sc_pkg::LB_X_W-1:0];
                cap_y      = y[sc_pkg::LB_Y_W-1:0];
                cap_r      = rng_state[23:16];
                cap_g      = rng_state[15:8];
                cap_b      = rng_state[7:0];
                @(negedge pclk_out);
            end
        end
        cap_we = 1'b0;
        reset  = 1'b0;
        watch_frames();
    endtask

    task automatic test_passthrough();
        begin_test();
        fill_and_watch();
    endtask

    task automatic test_repeat();
        begin_test();
        x_rpt = 4'd1;
        y_rpt = 4'd1;
        fill_and_watch();
    endtask

    task automatic test_scanlines();
        begin_test();
        y_rpt     = 4'd1;
        sl_enable = 1'b1;
        sl_str    = 4'd6;
        fill_and_watch();
    endtask

    // 6 by 2 window inside the active area
    task automatic test_mask();
        begin_test();
        mask_x_start = 12'd5;
        mask_x_size  = 12'd6;
        mask_y_start = 12'd1;
        mask_y_size  = 12'd2;
        mask_br      = 4'h3;
        fill_and_watch();
    endtask

    task automatic test_testpattern();
        begin_test();
        x_rpt        = 4'd1;
        y_rpt        = 4'd1;
        sl_enable    = 1'b1;
        sl_str       = 4'd9;
        mask_x_start = 12'd2;
        mask_x_size  = 12'd3;
        mask_br      = 4'hc;
        testpattern  = 1'b1;
        fill_and_watch();
    endtask

    initial begin
        pclk_out  = 1'b0;
        reset     = 1'b1;
        rng_state = 32'hbc68_8cab;
        set_defaults();
        test_passthrough();
        test_repeat();
        test_scanlines();
        test_mask();
        test_testpattern();
        $display("Test passed");
        $finish;
    end

endmodule

//--- verilog.f
sc_pkg.sv
sc_timing_gen.sv
sc_line_buffer.sv
sc_postproc.sv
scanconverter.sv
tb_scanconverter.sv

//--- run.sh
#!/bin/sh
# Build and run the scan converter testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module tb_scanconverter -f verilog.f

# The pipe keeps the log even when the simulation exits with an error
obj_dir/Vtb_scanconverter 2>&1 | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi

echo "Simulation finished without failures"
exit 0
